// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu.sv
`default_nettype none

module alu (
    input  isa_pkg::alu_op_e alu_op,
    input  isa_pkg::word_t   alu_a,
    input  isa_pkg::word_t   alu_b,
    output isa_pkg::word_t   alu_y
);

    // All operands signed, product keeps the low half
    always_comb
    begin
        case (alu_op)
            isa_pkg::ALU_ADD:
                alu_y = alu_a + alu_b;
            isa_pkg::ALU_SUB:
                alu_y = alu_a - alu_b;
            isa_pkg::ALU_SLT:
                alu_y = (alu_a < alu_b) ? 16'sd1 : 16'sd0;
            isa_pkg::ALU_MUL:
                alu_y = alu_a * alu_b;
            isa_pkg::ALU_INC:
                alu_y = alu_a + 16'sd1;
            default:
                alu_y = alu_a;
        endcase
    end

endmodule

`default_nettype wire

// File: core_ctrl.sv
`default_nettype none

module core_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    output logic              fetch_start,
    output mem_pkg::addr_t    pc,
    input  isa_pkg::instr_u   instr,
    input  logic              instr_valid,
    output isa_pkg::reg_idx_t rs_idx,
    output isa_pkg::reg_idx_t rt_idx,
    output isa_pkg::reg_idx_t wr_idx,
    output logic              wr_en,
    output isa_pkg::word_t    wr_data,
    input  isa_pkg::word_t    rd_data1,
    input  isa_pkg::word_t    rd_data2,
    output isa_pkg::alu_op_e  alu_op,
    output isa_pkg::word_t    alu_a,
    output isa_pkg::word_t    alu_b,
    input  isa_pkg::word_t    alu_y,
    output logic              ls_start,
    output logic              ls_we,
    output isa_pkg::word_t    ls_ea,
    output isa_pkg::word_t    ls_wdata,
    input  isa_pkg::word_t    ls_rdata,
    input  logic              ls_done,
    output logic              IO_stall
);

    // One flop per state: wb, mem wait, ex, id, if wait, if, boot
    logic [6:0]      state_q;
    logic [6:0]      state_d;
    logic            st_boot, st_if, st_wait, st_id, st_ex, st_mem, st_wb;
    mem_pkg::addr_t  pc_q;
    isa_pkg::instr_u ir_q;
    isa_pkg::word_t  opa_q;
    isa_pkg::word_t  opb_q;
    isa_pkg::word_t  alu_q;
    isa_pkg::word_t  imm_ext;
    logic            is_r, is_lw, is_sw, is_mem, is_beq, is_j, retire;

    assign {st_wb, st_mem, st_ex, st_id, st_wait, st_if, st_boot} = state_q;

    // ################################################
    // Decode, each format read through its own view
    // ################################################
    assign is_r   = (ir_q.r.opcode == isa_pkg::OP_ADD_SUB) ||
                    (ir_q.r.opcode == isa_pkg::OP_SLT_MULT);
    assign is_lw  = ir_q.i.opcode == isa_pkg::OP_LW;
    assign is_sw  = ir_q.i.opcode == isa_pkg::OP_SW;
    assign is_mem = is_lw | is_sw;
    assign is_beq = ir_q.i.opcode == isa_pkg::OP_BEQ;
    assign is_j   = ir_q.j.opcode == isa_pkg::OP_J;
    assign imm_ext = {{11{ir_q.i.imm[4]}}, ir_q.i.imm};

    // Branches, jumps and unknown opcodes finish in EX
    assign retire = st_wb | (st_ex & ~is_r & ~is_mem);

    assign state_d = {
        (st_ex & is_r) | (st_mem & ls_done),
        (st_ex & is_mem) | (st_mem & ~ls_done),
        st_id,
        st_wait & instr_valid,
        st_if | (st_wait & ~instr_valid),
        st_boot | st_wb | (st_ex & ~is_r & ~is_mem),
        1'b0
    };

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q  <= 7'b000_0001;
            pc_q     <= '0;
            ir_q     <= '0;
            IO_stall <= 1'b1;
        end
        else
        begin
            state_q  <= state_d;
            IO_stall <= ~retire;
            if (st_wait && instr_valid)
                ir_q <= instr;
            // PC+1 at fetch, target on taken BEQ or J
            if (st_if)
                pc_q <= mem_pkg::addr_t'(alu_y);
            else if (st_ex && is_beq && (opa_q == opb_q))
                pc_q <= mem_pkg::addr_t'(alu_y);
            else if (st_ex && is_j)
                pc_q <= {3'b000, ir_q.j.target};
        end
    end

    // Operand and result latches
    always_ff @(posedge clk)
    begin
        if (st_id)
        begin
            opa_q <= rd_data1;
            opb_q <= rd_data2;
        end
        if (st_ex)
            alu_q <= alu_y;
    end

    always_comb
    begin
        alu_op = isa_pkg::ALU_ADD;
        alu_a  = opa_q;
        alu_b  = opb_q;
        if (st_if)
        begin
            alu_op = isa_pkg::ALU_INC;
            alu_a  = isa_pkg::word_t'(pc_q);
        end
        else if (is_mem)
            alu_b = imm_ext;
        else if (is_beq)
        begin
            alu_a = isa_pkg::word_t'(pc_q);
            alu_b = imm_ext;
        end
        else if (ir_q.r.opcode == isa_pkg::OP_ADD_SUB)
            alu_op = ir_q.r.func ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
        else if (ir_q.r.opcode == isa_pkg::OP_SLT_MULT)
            alu_op = ir_q.r.func ? isa_pkg::ALU_MUL : isa_pkg::ALU_SLT;
    end

    assign fetch_start = st_if;
    assign pc          = pc_q;
    assign rs_idx      = ir_q.r.rs;
    assign rt_idx      = ir_q.r.rt;
    assign wr_idx      = is_r ? ir_q.r.rd : ir_q.i.rt;
    assign wr_en       = st_wb & (is_r | is_lw);
    assign wr_data     = is_r ? alu_q : ls_rdata;

    // Effective address goes straight from the ALU
    assign ls_start = st_ex & is_mem;
    assign ls_we    = is_sw;
    assign ls_ea    = alu_y;
    assign ls_wdata = opb_q;

    state_onehot_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state_q));

endmodule

`default_nettype wire

// File: cpu_top.sv
`default_nettype none

module cpu_top (
    input  logic           clk,
    input  logic           rst_n,
    output logic           mem_req,
    output logic           mem_we,
    output mem_pkg::addr_t mem_addr,
    output isa_pkg::word_t mem_wdata,
    input  isa_pkg::word_t mem_rdata,
    input  logic           mem_done,
    output logic           IO_stall
);

    // Core to fetch and load/store units
    logic             fetch_start;
    mem_pkg::addr_t   pc;
    isa_pkg::instr_u  instr;
    logic             instr_valid;
    logic             ls_start;
    logic             ls_we;
    isa_pkg::word_t   ls_ea;
    isa_pkg::word_t   ls_wdata;
    isa_pkg::word_t   ls_rdata;
    logic             ls_done;

    // Register file and ALU
    isa_pkg::reg_idx_t rs_idx;
    isa_pkg::reg_idx_t rt_idx;
    isa_pkg::reg_idx_t wr_idx;
    logic              wr_en;
    isa_pkg::word_t    wr_data;
    isa_pkg::word_t    rd_data1;
    isa_pkg::word_t    rd_data2;
    isa_pkg::alu_op_e  alu_op;
    isa_pkg::word_t    alu_a;
    isa_pkg::word_t    alu_b;
    isa_pkg::word_t    alu_y;

    mem_port_if fetch_if ();
    mem_port_if data_if ();

    core_ctrl core_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .pc          (pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .wr_idx      (wr_idx),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_y       (alu_y),
        .ls_start    (ls_start),
        .ls_we       (ls_we),
        .ls_ea       (ls_ea),
        .ls_wdata    (ls_wdata),
        .ls_rdata    (ls_rdata),
        .ls_done     (ls_done),
        .IO_stall    (IO_stall)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .wr_idx   (wr_idx),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    alu alu_i (
        .alu_op (alu_op),
        .alu_a  (alu_a),
        .alu_b  (alu_b),
        .alu_y  (alu_y)
    );

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .pc          (pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .port        (fetch_if)
    );

    load_store_unit load_store_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ls_start (ls_start),
        .ls_we    (ls_we),
        .ls_ea    (ls_ea),
        .ls_wdata (ls_wdata),
        .ls_rdata (ls_rdata),
        .ls_done  (ls_done),
        .port     (data_if)
    );

    mem_arbiter mem_arbiter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_port (fetch_if),
        .data_port  (data_if),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_done   (mem_done)
    );

endmodule

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_start,
    input  mem_pkg::addr_t  pc,
    output isa_pkg::instr_u instr,
    output logic            instr_valid,
    mem_port_if.requester   port
);

    logic           req_q;
    logic           valid_q;
    mem_pkg::addr_t addr_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_q   <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            req_q   <= fetch_start;
            valid_q <= port.done;
        end
    end

    // Address held until done, word captured with done
    always_ff @(posedge clk)
    begin
        if (fetch_start)
            addr_q <= pc << mem_pkg::INSTR_SHIFT;
        if (port.done)
            instr <= isa_pkg::instr_u'(port.rdata);
    end

    assign port.req    = req_q;
    assign port.we     = 1'b0;
    assign port.addr   = addr_q;
    assign port.wdata  = '0;
    assign instr_valid = valid_q;

    one_fetch_a: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_start |=> (!fetch_start until_with instr_valid));

endmodule

`default_nettype wire

// File: filelist.f
isa_pkg.sv
mem_pkg.sv
mem_port_if.sv
alu.sv
reg_file.sv
fetch_unit.sv
load_store_unit.sv
mem_arbiter.sv
core_ctrl.sv
cpu_top.sv
tb_clk_gen.sv
tb_top.sv

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Register file geometry
    localparam int NUM_REGS = 16;

    typedef logic signed [15:0] word_t;
    typedef logic [3:0] reg_idx_t;

    // Opcode field, func picks the member inside groups 0 and 1
    typedef enum logic [2:0] {
        OP_ADD_SUB  = 3'd0,
        OP_SLT_MULT = 3'd1,
        OP_LW       = 3'd2,
        OP_SW       = 3'd3,
        OP_BEQ      = 3'd4,
        OP_J        = 3'd5
    } opcode_e;

    // ################################################
    // Instruction formats, all 16 bits wide
    // ################################################
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     func;
    } r_fmt_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [4:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [12:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_MUL,
        ALU_INC
    } alu_op_e;

endpackage

`default_nettype wire

// File: load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ls_start,
    input  logic           ls_we,
    input  isa_pkg::word_t ls_ea,
    input  isa_pkg::word_t ls_wdata,
    output isa_pkg::word_t ls_rdata,
    output logic           ls_done,
    mem_port_if.requester  port
);

    logic           req_q;
    logic           done_q;
    logic           we_q;
    mem_pkg::addr_t addr_q;
    isa_pkg::word_t wdata_q;
    isa_pkg::word_t rdata_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_q  <= 1'b0;
            done_q <= 1'b0;
            we_q   <= 1'b0;
        end
        else
        begin
            req_q  <= ls_start;
            done_q <= port.done;
            if (ls_start)
                we_q <= ls_we;
        end
    end

    // Word index into the data region, two bytes per word
    always_ff @(posedge clk)
    begin
        if (ls_start)
        begin
            addr_q  <= mem_pkg::DATA_BASE + (mem_pkg::addr_t'(ls_ea) << 1);
            wdata_q <= ls_wdata;
        end
        if (port.done && !we_q)
            rdata_q <= port.rdata;
    end

    assign port.req   = req_q;
    assign port.we    = we_q;
    assign port.addr  = addr_q;
    assign port.wdata = wdata_q;
    assign ls_rdata   = rdata_q;
    assign ls_done    = done_q;

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  logic           clk,
    input  logic           rst_n,
    mem_port_if.arbiter    fetch_port,
    mem_port_if.arbiter    data_port,
    output logic           mem_req,
    output logic           mem_we,
    output mem_pkg::addr_t mem_addr,
    output isa_pkg::word_t mem_wdata,
    input  isa_pkg::word_t mem_rdata,
    input  logic           mem_done
);

    logic [mem_pkg::NUM_REQ-1:0] req_vec;
    logic [mem_pkg::NUM_REQ-1:0] pend_q;
    logic [mem_pkg::NUM_REQ-1:0] want;
    logic [mem_pkg::NUM_REQ-1:0] grant;
    logic [mem_pkg::NUM_REQ-1:0] owner_q;
    logic                        busy_q;
    logic                        issue;
    logic                        sel_data;

    assign req_vec[mem_pkg::REQ_FETCH] = fetch_port.req;
    assign req_vec[mem_pkg::REQ_DATA]  = data_port.req;
    assign want  = req_vec | pend_q;
    assign issue = !busy_q && (|want);

    // ################################################
    // Fixed priority, data wins over fetch
    // ################################################
    always_comb
    begin
        grant = '0;
        if (want[mem_pkg::REQ_DATA])
            grant[mem_pkg::REQ_DATA] = 1'b1;
        else if (want[mem_pkg::REQ_FETCH])
            grant[mem_pkg::REQ_FETCH] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend_q  <= '0;
            owner_q <= '0;
            busy_q  <= 1'b0;
        end
        else
        begin
            // Losers and late arrivals wait here
            pend_q <= want & ~(issue ? grant : '0);
            if (issue)
            begin
                owner_q <= grant;
                busy_q  <= 1'b1;
            end
            else if (mem_done)
            begin
                busy_q <= 1'b0;
            end
        end
    end

    assign sel_data  = issue ? grant[mem_pkg::REQ_DATA] : owner_q[mem_pkg::REQ_DATA];
    assign mem_req   = issue;
    assign mem_we    = sel_data ? data_port.we : fetch_port.we;
    assign mem_addr  = sel_data ? data_port.addr : fetch_port.addr;
    assign mem_wdata = sel_data ? data_port.wdata : fetch_port.wdata;

    // Completion only reaches the current owner
    assign fetch_port.done  = mem_done & owner_q[mem_pkg::REQ_FETCH];
    assign data_port.done   = mem_done & owner_q[mem_pkg::REQ_DATA];
    assign fetch_port.rdata = owner_q[mem_pkg::REQ_FETCH] ? mem_rdata : '0;
    assign data_port.rdata  = owner_q[mem_pkg::REQ_DATA] ? mem_rdata : '0;

    one_outstanding_a: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |=> (!mem_req until_with mem_done));

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [15:0] addr_t;

    // Data words live above the program
    localparam addr_t DATA_BASE = 16'h1000;

    // Instructions are 2 bytes, byte address is pc << 1
    localparam int INSTR_SHIFT = 1;

    // Requester slots on the shared port
    localparam int REQ_FETCH = 0;
    localparam int REQ_DATA  = 1;
    localparam int NUM_REQ   = 2;

endpackage

`default_nettype wire

// File: mem_port_if.sv
`default_nettype none

interface mem_port_if;

    logic           req;
    logic           we;
    mem_pkg::addr_t addr;
    isa_pkg::word_t wdata;
    isa_pkg::word_t rdata;
    logic           done;

    // Unit side, holds addr and data until done
    modport requester (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, done
    );

endinterface

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t rs_idx,
    input  isa_pkg::reg_idx_t rt_idx,
    input  isa_pkg::reg_idx_t wr_idx,
    input  logic              wr_en,
    input  isa_pkg::word_t    wr_data,
    output isa_pkg::word_t    rd_data1,
    output isa_pkg::word_t    rd_data2
);

    isa_pkg::word_t regs_q [isa_pkg::NUM_REGS];

    // r0 is an ordinary register here
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else if (wr_en)
        begin
            regs_q[wr_idx] <= wr_data;
        end
    end

    assign rd_data1 = regs_q[rs_idx];
    assign rd_data2 = regs_q[rt_idx];

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 4;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release 1 ns after the edge, like the other driven inputs
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_top.sv
`default_nettype none

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MAX_DELAY        = 4;
    localparam int          CYCLES_PER_INSTR = 40;
    localparam int          MAX_MODEL_STEPS  = 200;
    localparam int unsigned RAND_SEED        = 32'h4fca_395d;

    logic           clk;
    logic           rst_n;
    logic           mem_req;
    logic           mem_we;
    mem_pkg::addr_t mem_addr;
    isa_pkg::word_t mem_wdata;
    isa_pkg::word_t mem_rdata;
    logic           mem_done;
    logic           IO_stall;

    // Sparse memories behind the DUT and behind the ISA model
    logic [15:0] dut_mem [mem_pkg::addr_t];
    logic [15:0] ref_mem [mem_pkg::addr_t];

    // Expected port traffic with one entry per transaction
    logic           exp_we [$];
    mem_pkg::addr_t exp_addr [$];
    isa_pkg::word_t exp_wdata [$];
    int             retire_txn [$];

    int   load_pc         = 0;
    int   exp_count       = 0;
    int   watchdog_cycles = 0;
    int   txn_seen        = 0;
    int   retired         = 0;
    logic bus_busy        = 1'b0;
    logic stall_prev      = 1'b1;

    tb_clk_gen tb_clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cpu_top cpu_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_done  (mem_done),
        .IO_stall  (IO_stall)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(string name, logic [15:0] got, logic [15:0] exp);
        abort_run($sformatf("[ERROR] %s: got 0x%04h, expected 0x%04h (transaction %0d)",
                            name, got, exp, txn_seen));
    endtask

    // Unwritten words read back as a pattern of their own address
    function automatic logic [15:0] fill_word(mem_pkg::addr_t a);
        return a ^ 16'hc3a5;
    endfunction

    function automatic logic [15:0] dut_word(mem_pkg::addr_t a);
        return dut_mem.exists(a) ? dut_mem[a] : fill_word(a);
    endfunction

    function automatic logic [15:0] ref_word(mem_pkg::addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    // ################################################
    // Instruction encoders
    // ################################################
    function automatic isa_pkg::word_t r_instr(isa_pkg::opcode_e op, int rs, int rt, int rd,
                                               logic func);
        isa_pkg::instr_u w;
        w.r.opcode = op;
        w.r.rs     = isa_pkg::reg_idx_t'(rs);
        w.r.rt     = isa_pkg::reg_idx_t'(rt);
        w.r.rd     = isa_pkg::reg_idx_t'(rd);
        w.r.func   = func;
        return isa_pkg::word_t'(w);
    endfunction

    function automatic isa_pkg::word_t imm_instr(isa_pkg::opcode_e op, int rs, int rt, int imm);
        isa_pkg::instr_u w;
        w.i.opcode = op;
        w.i.rs     = isa_pkg::reg_idx_t'(rs);
        w.i.rt     = isa_pkg::reg_idx_t'(rt);
        w.i.imm    = 5'(imm);
        return isa_pkg::word_t'(w);
    endfunction

    function automatic isa_pkg::word_t jump_instr(int target);
        isa_pkg::instr_u w;
        w.j.opcode = isa_pkg::OP_J;
        w.j.target = 13'(target);
        return isa_pkg::word_t'(w);
    endfunction

    task automatic place_instr(isa_pkg::word_t w);
        mem_pkg::addr_t a;
        a = mem_pkg::addr_t'(load_pc) << mem_pkg::INSTR_SHIFT;
        dut_mem[a] = w;
        ref_mem[a] = w;
        load_pc++;
    endtask

    task automatic seed_data(int idx, logic [15:0] value);
        mem_pkg::addr_t a;
        a = mem_pkg::DATA_BASE + (mem_pkg::addr_t'(idx) << 1);
        dut_mem[a] = value;
        ref_mem[a] = value;
    endtask

    task automatic load_program();
        seed_data(0, 16'h0007);
        seed_data(1, 16'hfffd);
        seed_data(2, 16'h0300);
        seed_data(3, 16'h0123);
        place_instr(imm_instr(isa_pkg::OP_LW, 0, 1, 0));          // 0
        place_instr(imm_instr(isa_pkg::OP_LW, 0, 2, 1));
        place_instr(imm_instr(isa_pkg::OP_LW, 0, 3, 2));
        place_instr(imm_instr(isa_pkg::OP_LW, 0, 4, 3));
        place_instr(r_instr(isa_pkg::OP_ADD_SUB, 1, 2, 5, 1'b0));  // 4 adds 7 and -3
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 5, 8));
        place_instr(r_instr(isa_pkg::OP_ADD_SUB, 2, 1, 6, 1'b1));  // -3 - 7
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 6, 9));
        place_instr(r_instr(isa_pkg::OP_SLT_MULT, 2, 1, 7, 1'b0)); // 8
        place_instr(r_instr(isa_pkg::OP_SLT_MULT, 1, 2, 8, 1'b0));
        // 768 * 291 overflows 16 bits
        place_instr(r_instr(isa_pkg::OP_SLT_MULT, 3, 4, 9, 1'b1));
        place_instr(r_instr(isa_pkg::OP_SLT_MULT, 2, 1, 10, 1'b1));
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 7, 10));          // 12
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 8, 11));
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 9, 12));
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 10, 13));
        place_instr(imm_instr(isa_pkg::OP_BEQ, 1, 2, 3));          // 16 not taken
        place_instr(imm_instr(isa_pkg::OP_LW, 0, 11, 0));
        place_instr(imm_instr(isa_pkg::OP_BEQ, 1, 11, 2));         // 18 taken to 21
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 1, 14));
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 1, 15));
        place_instr(jump_instr(24));                               // 21
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 2, 14));
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 2, 15));
        place_instr(r_instr(isa_pkg::OP_ADD_SUB, 0, 1, 12, 1'b1)); // 24
        place_instr(imm_instr(isa_pkg::OP_SW, 1, 12, -1));         // negative offset
        place_instr(imm_instr(isa_pkg::OP_LW, 0, 13, 6));
        place_instr(r_instr(isa_pkg::OP_ADD_SUB, 13, 13, 14, 1'b0));
        place_instr(imm_instr(isa_pkg::OP_SW, 0, 14, 7));
        place_instr(jump_instr(29));                               // 29 halt loop
    endtask

    task automatic record_access(logic we, mem_pkg::addr_t a, isa_pkg::word_t d);
        exp_we.push_back(we);
        exp_addr.push_back(a);
        exp_wdata.push_back(d);
    endtask

    // ################################################
    // ISA model running until the jump-to-self
    // ################################################
    task automatic run_reference();
        isa_pkg::word_t  regs [isa_pkg::NUM_REGS];
        isa_pkg::instr_u ins;
        mem_pkg::addr_t  pc;
        mem_pkg::addr_t  next_pc;
        mem_pkg::addr_t  daddr;
        isa_pkg::word_t  a;
        isa_pkg::word_t  b;
        isa_pkg::word_t  imm;
        int              prod;
        int              steps;
        logic            halt;
        for (int i = 0; i < isa_pkg::NUM_REGS; i++)
            regs[i] = '0;
        pc    = '0;
        steps = 0;
        halt  = 1'b0;
        while (!halt && steps < MAX_MODEL_STEPS)
        begin
            daddr = pc << mem_pkg::INSTR_SHIFT;
            ins   = ref_word(daddr);
            record_access(1'b0, daddr, '0);
            a       = regs[ins.r.rs];
            b       = regs[ins.r.rt];
            imm     = isa_pkg::word_t'($signed(ins.i.imm));
            next_pc = pc + 16'd1;
            case (ins.r.opcode)
                isa_pkg::OP_ADD_SUB:
                    regs[ins.r.rd] = ins.r.func ? a - b : a + b;
                isa_pkg::OP_SLT_MULT:
                begin
                    prod = int'(a) * int'(b);
                    if (ins.r.func)
                        regs[ins.r.rd] = isa_pkg::word_t'(prod[15:0]);
                    else
                        regs[ins.r.rd] = (int'(a) < int'(b)) ? 16'sd1 : 16'sd0;
                end
                isa_pkg::OP_LW:
                begin
                    daddr = mem_pkg::DATA_BASE + (mem_pkg::addr_t'(a + imm) << 1);
                    regs[ins.i.rt] = ref_word(daddr);
                    record_access(1'b0, daddr, '0);
                end
                isa_pkg::OP_SW:
                begin
                    daddr = mem_pkg::DATA_BASE + (mem_pkg::addr_t'(a + imm) << 1);
                    ref_mem[daddr] = b;
                    record_access(1'b1, daddr, b);
                end
                isa_pkg::OP_BEQ:
                    if (a == b)
                        next_pc = pc + 16'd1 + mem_pkg::addr_t'(imm);
                isa_pkg::OP_J:
                begin
                    next_pc = mem_pkg::addr_t'(ins.j.target);
                    halt    = (next_pc == pc);
                end
                default:
                    ;
            endcase
            retire_txn.push_back(exp_addr.size());
            pc = next_pc;
            steps++;
        end
        if (!halt)
            abort_run("Reference model never reached the halt loop");
    endtask

    // Memory model answering 1 to MAX_DELAY cycles after each request
    initial
    begin
        int unsigned    delay;
        mem_pkg::addr_t addr;
        void'($urandom(RAND_SEED));
        mem_done  = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (rst_n && mem_req)
            begin
                addr = mem_addr;
                if (mem_we)
                    dut_mem[addr] = mem_wdata;
                delay = $urandom_range(MAX_DELAY, 1);
                repeat (delay) @(posedge clk);
                #1;
                mem_done  = 1'b1;
                mem_rdata = dut_word(addr);
                @(posedge clk);
                #1;
                mem_done = 1'b0;
            end
        end
    end

    // ################################################
    // Bus and retirement monitor
    // ################################################
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            reset_stall_a: assert (IO_stall)
                else abort_run("IO_stall went low while reset was asserted");
            stall_prev = 1'b1;
        end
        else
        begin
            no_overlap_a: assert (!(mem_req && bus_busy))
                else abort_run("mem_req issued while a memory transaction was outstanding");
            if (mem_done)
                bus_busy = 1'b0;
            if (mem_req)
                bus_busy = 1'b1;
            if (mem_req && retired < exp_count)
            begin
                trace_len_a: assert (txn_seen < exp_addr.size())
                    else abort_run("More memory transactions than the program should make");
                we_a: assert (mem_we == exp_we[txn_seen])
                    else report_mismatch("mem_we", {15'd0, mem_we}, {15'd0, exp_we[txn_seen]});
                addr_a: assert (mem_addr == exp_addr[txn_seen])
                    else report_mismatch("mem_addr", mem_addr, exp_addr[txn_seen]);
                if (mem_we)
                begin
                    wdata_a: assert (mem_wdata == exp_wdata[txn_seen])
                        else report_mismatch("mem_wdata", mem_wdata, exp_wdata[txn_seen]);
                end
                txn_seen++;
            end
            if (!IO_stall && retired < exp_count)
            begin
                single_a: assert (stall_prev)
                    else abort_run("IO_stall stayed low for more than one cycle");
                in_step_a: assert (txn_seen == retire_txn[retired])
                    else abort_run($sformatf(
                        "Instruction %0d retired after %0d memory transactions instead of %0d",
                        retired, txn_seen, retire_txn[retired]));
                retired++;
            end
            stall_prev = IO_stall;
        end
    end

    initial
    begin
        wait (watchdog_cycles > 0);
        wait (rst_n === 1'b1);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("Watchdog expired after %0d cycles, program did not finish",
                            watchdog_cycles));
    end

    initial
    begin
        load_program();
        run_reference();
        exp_count       = retire_txn.size();
        watchdog_cycles = exp_count * CYCLES_PER_INSTR + MAX_DELAY;
        wait (rst_n === 1'b1);
        wait (retired == exp_count);
        // Halt loop refetches so no retirement fits in the next few cycles
        repeat (3)
        begin
            @(negedge clk);
            halt_stall_a: assert (IO_stall)
                else abort_run("IO_stall dropped again right after the final instruction");
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
